/* source/cpu_pkg.sv */
package cpu_pkg;

  localparam int ADDR_W     = 10;
  localparam int PAGE_BYTES = 64;
  localparam int NUM_SEGS   = 16;
  localparam int NUM_REGS   = 16;
  localparam int REG_W      = 16;

  localparam logic [7:0] OP_JMP     = 8'd1;
  localparam logic [7:0] OP_RAM2REG = 8'd2;
  localparam logic [7:0] OP_REG2RAM = 8'd3;
  localparam logic [7:0] OP_NUM2REG = 8'd4;
  localparam logic [7:0] OP_HALT    = 8'd15;

  // host address map, byte addresses on the AXI4-Lite bus
  localparam logic [15:0] REG_CTRL      = 16'h0000;
  localparam logic [15:0] REG_START_SEG = 16'h0004;
  localparam logic [15:0] REG_SEG_BASE  = 16'h0100;
  localparam logic [15:0] MEM_BASE      = 16'h1000;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
  } mem_req_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [7:0]  reg_sel;
    logic [15:0] operand; // byte 3 high, byte 4 low
  } instr_t;

  typedef struct packed {
    logic              valid;
    logic              jump;
    logic [ADDR_W-1:0] target;
  } exec_done_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] seg;
    logic [7:0] next_seg;
    logic [7:0] logical_page;
  } seg_cfg_t;

  typedef struct packed {
    logic halt;
    logic fault;
  } core_event_t;

  typedef struct packed {
    logic        awvalid;
    logic [15:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic        bready;
    logic        arvalid;
    logic [15:0] araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

endpackage

/* source/byte_memory.sv */
`timescale 1ns/10ps

module byte_memory #(
  parameter int ADDR_W = cpu_pkg::ADDR_W
) (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::mem_req_t host_req,
  input  cpu_pkg::mem_req_t core_req,
  output cpu_pkg::mem_rsp_t host_rsp,
  output cpu_pkg::mem_rsp_t core_rsp
);

  logic [7:0]        mem [2**ADDR_W];
  cpu_pkg::mem_req_t sel_req;
  logic              host_valid, core_valid;
  logic [7:0]        rdata_q;

  assign sel_req  = host_req.valid ? host_req : core_req; // host wins
  assign host_rsp = '{valid: host_valid, rdata: rdata_q};
  assign core_rsp = '{valid: core_valid, rdata: rdata_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int a = 0; a < 2**ADDR_W; a++) mem[a] <= 8'h00;
      host_valid <= 1'b0;
      core_valid <= 1'b0;
    end else begin
      host_valid <= host_req.valid;
      core_valid <= core_req.valid && !host_req.valid;
      if (sel_req.valid && sel_req.write) mem[sel_req.addr[ADDR_W-1:0]] <= sel_req.wdata;
      rdata_q <= mem[sel_req.addr[ADDR_W-1:0]]; // old data on write
    end
  end

endmodule

/* source/page_translator.sv */
`timescale 1ns/10ps

module page_translator #(
  parameter int ADDR_W     = cpu_pkg::ADDR_W,
  parameter int PAGE_BYTES = cpu_pkg::PAGE_BYTES,
  parameter int NUM_SEGS   = cpu_pkg::NUM_SEGS
) (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::seg_cfg_t seg_cfg,
  input  logic [7:0]        start_seg,
  input  cpu_pkg::mem_req_t fetch_req,
  input  cpu_pkg::mem_req_t exec_req,
  output cpu_pkg::mem_rsp_t fetch_rsp,
  output cpu_pkg::mem_rsp_t exec_rsp,
  output cpu_pkg::mem_req_t phys_req,
  input  cpu_pkg::mem_rsp_t phys_rsp,
  output logic              fault
);

  localparam int OFF_W = $clog2(PAGE_BYTES);
  localparam int SEG_W = $clog2(NUM_SEGS);

  logic [SEG_W-1:0]  next_tab [NUM_SEGS];
  logic [7:0]        page_tab [NUM_SEGS];
  cpu_pkg::mem_req_t new_req, pend;
  logic              who; // 1 = executor
  logic              walking, wait_rsp;
  logic [SEG_W-1:0]  root, cur_seg;
  logic [7:0]        new_page, pend_page;

  assign root      = start_seg[SEG_W-1:0];
  assign new_req   = exec_req.valid ? exec_req : fetch_req; // executor first
  assign new_page  = 8'(new_req.addr[ADDR_W-1:OFF_W]);
  assign pend_page = 8'(pend.addr[ADDR_W-1:OFF_W]);

  assign fetch_rsp = '{valid: wait_rsp && phys_rsp.valid && !who, rdata: phys_rsp.rdata};
  assign exec_rsp  = '{valid: wait_rsp && phys_rsp.valid && who, rdata: phys_rsp.rdata};

  function automatic logic [ADDR_W-1:0] phys_addr(input logic [SEG_W-1:0] seg,
                                                  input logic [ADDR_W-1:0] laddr);
    return ADDR_W'(seg) * ADDR_W'(PAGE_BYTES) + ADDR_W'(laddr[OFF_W-1:0]);
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < NUM_SEGS; s++) begin
        next_tab[s] <= SEG_W'(s); // every segment ends its own chain
        page_tab[s] <= 8'h00;
      end
    end else if (seg_cfg.valid) begin
      next_tab[seg_cfg.seg[SEG_W-1:0]] <= seg_cfg.next_seg[SEG_W-1:0];
      page_tab[seg_cfg.seg[SEG_W-1:0]] <= seg_cfg.logical_page;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      walking        <= 1'b0;
      wait_rsp       <= 1'b0;
      fault          <= 1'b0;
      phys_req.valid <= 1'b0;
    end else begin
      phys_req.valid <= 1'b0;
      fault          <= 1'b0;
      if (!walking && !wait_rsp && new_req.valid) begin
        pend <= new_req;
        who  <= exec_req.valid;
        if (new_page == 8'h00 || page_tab[root] == new_page) begin
          phys_req <= '{1'b1, new_req.write, phys_addr(root, new_req.addr), new_req.wdata};
          wait_rsp <= 1'b1;
        end else if (next_tab[root] == root) begin
          fault <= 1'b1; // single-segment chain, no match
        end else begin
          cur_seg <= next_tab[root];
          walking <= 1'b1;
        end
      end else if (walking) begin
        if (page_tab[cur_seg] == pend_page) begin
          phys_req <= '{1'b1, pend.write, phys_addr(cur_seg, pend.addr), pend.wdata};
          walking  <= 1'b0;
          wait_rsp <= 1'b1;
        end else if (next_tab[cur_seg] == cur_seg) begin
          fault   <= 1'b1; // end of chain reached
          walking <= 1'b0;
        end else begin
          cur_seg <= next_tab[cur_seg]; // one hop per cycle
        end
      end else if (wait_rsp && phys_rsp.valid) begin
        wait_rsp <= 1'b0;
      end
    end
  end

endmodule

/* source/host_port.sv */
`timescale 1ns/10ps

module host_port #(
  parameter int ADDR_W   = cpu_pkg::ADDR_W,
  parameter int NUM_SEGS = cpu_pkg::NUM_SEGS
) (
  input  logic                 clk,
  input  logic                 rst,
  input  cpu_pkg::axil_req_t   axil_req,
  output cpu_pkg::axil_rsp_t   axil_rsp,
  output logic                 run,
  input  cpu_pkg::core_event_t core_event,
  output cpu_pkg::seg_cfg_t    seg_cfg,
  output logic [7:0]           start_seg,
  output cpu_pkg::mem_req_t    mem_req,
  input  cpu_pkg::mem_rsp_t    mem_rsp
);

  localparam int MEM_TOP = cpu_pkg::MEM_BASE + 4 * (2 ** ADDR_W);
  localparam int SEG_TOP = cpu_pkg::REG_SEG_BASE + 4 * NUM_SEGS;

  logic        fault;
  logic        bvalid, rvalid, rd_wait;
  logic [1:0]  bresp, rresp;
  logic [31:0] rdata;
  logic        busy, wr_go, rd_go;
  logic [15:0] waddr, raddr;
  logic [31:0] wdata;
  logic        w_mem, w_seg, r_mem, r_seg;

  assign waddr = axil_req.awaddr;
  assign raddr = axil_req.araddr;
  assign wdata = axil_req.wdata;
  assign w_mem = waddr >= cpu_pkg::MEM_BASE && 32'(waddr) < MEM_TOP;
  assign w_seg = waddr >= cpu_pkg::REG_SEG_BASE && 32'(waddr) < SEG_TOP;
  assign r_mem = raddr >= cpu_pkg::MEM_BASE && 32'(raddr) < MEM_TOP;
  assign r_seg = raddr >= cpu_pkg::REG_SEG_BASE && 32'(raddr) < SEG_TOP;

  // one transfer in flight, a pending response stalls the next one
  assign busy  = bvalid || rvalid || rd_wait;
  assign wr_go = axil_req.awvalid && axil_req.wvalid && !busy;
  assign rd_go = axil_req.arvalid && !busy && !wr_go;

  assign axil_rsp = '{awready: wr_go, wready: wr_go, bvalid: bvalid, bresp: bresp,
                      arready: rd_go, rvalid: rvalid, rdata: rdata, rresp: rresp};

  always_ff @(posedge clk) begin
    if (rst) begin
      run           <= 1'b0;
      fault         <= 1'b0;
      start_seg     <= 8'h00;
      bvalid        <= 1'b0;
      rvalid        <= 1'b0;
      rd_wait       <= 1'b0;
      seg_cfg.valid <= 1'b0;
      mem_req.valid <= 1'b0;
    end else begin
      seg_cfg.valid <= 1'b0;
      mem_req.valid <= 1'b0;
      if (bvalid && axil_req.bready) bvalid <= 1'b0;
      if (rvalid && axil_req.rready) rvalid <= 1'b0;

      if (wr_go) begin
        bvalid <= 1'b1;
        bresp  <= cpu_pkg::RESP_OKAY;
        if (waddr == cpu_pkg::REG_CTRL) begin
          run <= wdata[0];
          if (wdata[0]) fault <= 1'b0; // new run clears old fault
        end else if (waddr == cpu_pkg::REG_START_SEG) begin
          start_seg <= wdata[7:0];
        end else if ((w_mem || w_seg) && run) begin
          bresp <= cpu_pkg::RESP_SLVERR; // dropped while core owns memory
        end else if (w_seg) begin
          seg_cfg <= '{1'b1, 8'((waddr - cpu_pkg::REG_SEG_BASE) >> 2), wdata[7:0], wdata[15:8]};
        end else if (w_mem) begin
          mem_req <= '{1'b1, 1'b1, waddr[ADDR_W+1:2], wdata[7:0]};
        end
      end

      if (rd_go) begin
        rresp   <= ((r_mem || r_seg) && run) ? cpu_pkg::RESP_SLVERR : cpu_pkg::RESP_OKAY;
        rdata   <= 32'h0; // chain table reads back as zero
        rvalid  <= !(r_mem && !run);
        rd_wait <= r_mem && !run;
        if (raddr == cpu_pkg::REG_CTRL) begin
          rdata <= {30'h0, fault, run};
        end else if (raddr == cpu_pkg::REG_START_SEG) begin
          rdata <= {24'h0, start_seg};
        end else if (r_mem && !run) begin
          mem_req <= '{1'b1, 1'b0, raddr[ADDR_W+1:2], 8'h00};
        end
      end

      if (rd_wait && mem_rsp.valid) begin
        rdata   <= {24'h0, mem_rsp.rdata};
        rvalid  <= 1'b1;
        rd_wait <= 1'b0;
      end

      // core events win over a host write in the same cycle
      if (core_event.halt || core_event.fault) run <= 1'b0;
      if (core_event.fault) fault <= 1'b1;
    end
  end

endmodule

/* source/instr_fetcher.sv */
`timescale 1ns/10ps

module instr_fetcher #(
  parameter int ADDR_W = cpu_pkg::ADDR_W
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                run,
  output cpu_pkg::mem_req_t   mem_req,
  input  cpu_pkg::mem_rsp_t   mem_rsp,
  output cpu_pkg::instr_t     instr,
  output logic                instr_valid,
  input  cpu_pkg::exec_done_t done
);

  logic [ADDR_W-1:0] pc, next_pc;
  logic [1:0]        byte_cnt;
  logic [23:0]       head; // first three bytes of the word
  logic              run_q;

  assign next_pc = done.jump ? done.target[ADDR_W-1:0] : pc + ADDR_W'(4);

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q         <= 1'b0;
      pc            <= '0;
      byte_cnt      <= 2'd0;
      mem_req.valid <= 1'b0;
      instr_valid   <= 1'b0;
    end else begin
      run_q         <= run;
      mem_req.valid <= 1'b0;
      instr_valid   <= 1'b0;
      if (run && !run_q) begin
        pc       <= '0; // fresh run starts at 0
        byte_cnt <= 2'd0;
        mem_req  <= '{1'b1, 1'b0, '0, 8'h00};
      end else if (run && mem_rsp.valid) begin
        if (byte_cnt == 2'd3) begin
          instr       <= {head, mem_rsp.rdata};
          instr_valid <= 1'b1;
        end else begin
          mem_req <= '{1'b1, 1'b0, pc + ADDR_W'(byte_cnt) + ADDR_W'(1), 8'h00};
        end
        head     <= {head[15:0], mem_rsp.rdata};
        byte_cnt <= byte_cnt + 2'd1; // wraps to 0 after the last byte
      end else if (run && done.valid) begin
        pc      <= next_pc;
        mem_req <= '{1'b1, 1'b0, next_pc, 8'h00};
      end
    end
  end

endmodule

/* source/instr_executor.sv */
`timescale 1ns/10ps

module instr_executor #(
  parameter int ADDR_W = cpu_pkg::ADDR_W
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                run,
  input  cpu_pkg::instr_t     instr,
  input  logic                instr_valid,
  output cpu_pkg::mem_req_t   mem_req,
  input  cpu_pkg::mem_rsp_t   mem_rsp,
  output cpu_pkg::exec_done_t done,
  output logic                halt
);

  localparam int SEL_W = $clog2(cpu_pkg::NUM_REGS);

  logic [cpu_pkg::REG_W-1:0] regs [cpu_pkg::NUM_REGS];
  logic [SEL_W-1:0]          sel, load_sel;
  logic                      waiting, loading;

  assign sel = instr.reg_sel[SEL_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < cpu_pkg::NUM_REGS; r++) regs[r] <= '0;
      waiting       <= 1'b0;
      loading       <= 1'b0;
      mem_req.valid <= 1'b0;
      done.valid    <= 1'b0;
      halt          <= 1'b0;
    end else begin
      mem_req.valid <= 1'b0;
      done.valid    <= 1'b0;
      halt          <= 1'b0;
      if (!run) begin
        waiting <= 1'b0; // stopped, drop any pending access
      end else if (waiting) begin
        if (mem_rsp.valid) begin
          if (loading) regs[load_sel] <= cpu_pkg::REG_W'(mem_rsp.rdata);
          done.valid <= 1'b1;
          done.jump  <= 1'b0;
          waiting    <= 1'b0;
        end
      end else if (instr_valid) begin
        done.jump   <= 1'b0;
        done.target <= instr.operand[ADDR_W-1:0];
        case (instr.opcode)
          cpu_pkg::OP_NUM2REG: begin
            regs[sel]  <= cpu_pkg::REG_W'(instr.operand);
            done.valid <= 1'b1;
          end
          cpu_pkg::OP_JMP: begin
            done.valid <= 1'b1;
            done.jump  <= 1'b1;
          end
          cpu_pkg::OP_RAM2REG, cpu_pkg::OP_REG2RAM: begin
            mem_req  <= '{1'b1, instr.opcode == cpu_pkg::OP_REG2RAM,
                          instr.operand[ADDR_W-1:0], regs[sel][7:0]};
            waiting  <= 1'b1;
            loading  <= instr.opcode == cpu_pkg::OP_RAM2REG;
            load_sel <= sel;
          end
          cpu_pkg::OP_HALT: halt <= 1'b1; // no done, fetcher stays idle
          default: done.valid <= 1'b1;    // unknown opcode is a no-op
        endcase
      end
    end
  end

endmodule

/* source/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top #(
  parameter int ADDR_W     = cpu_pkg::ADDR_W,
  parameter int PAGE_BYTES = cpu_pkg::PAGE_BYTES,
  parameter int NUM_SEGS   = cpu_pkg::NUM_SEGS
) (
  input  logic               clk,
  input  logic               rst,
  input  cpu_pkg::axil_req_t axil_req,
  output cpu_pkg::axil_rsp_t axil_rsp
);

  logic                 run;
  logic                 halt;
  logic                 fault;
  logic [7:0]           start_seg;
  logic                 instr_valid;
  cpu_pkg::core_event_t core_event;
  cpu_pkg::seg_cfg_t    seg_cfg;
  cpu_pkg::instr_t      instr;
  cpu_pkg::exec_done_t  done;
  cpu_pkg::mem_req_t    host_req, phys_req, fetch_req, exec_req;
  cpu_pkg::mem_rsp_t    host_rsp, phys_rsp, fetch_rsp, exec_rsp;

  assign core_event = '{halt: halt, fault: fault};

  host_port #(.ADDR_W(ADDR_W), .NUM_SEGS(NUM_SEGS)) host_port_i (
    .clk, .rst, .axil_req, .axil_rsp, .run, .core_event, .seg_cfg, .start_seg,
    .mem_req(host_req), .mem_rsp(host_rsp)
  );

  page_translator #(.ADDR_W(ADDR_W), .PAGE_BYTES(PAGE_BYTES), .NUM_SEGS(NUM_SEGS))
  page_translator_i (
    .clk, .rst, .seg_cfg, .start_seg, .fetch_req, .exec_req, .fetch_rsp, .exec_rsp,
    .phys_req, .phys_rsp, .fault
  );

  byte_memory #(.ADDR_W(ADDR_W)) byte_memory_i (
    .clk, .rst, .host_req, .core_req(phys_req), .host_rsp, .core_rsp(phys_rsp)
  );

  instr_fetcher #(.ADDR_W(ADDR_W)) instr_fetcher_i (
    .clk, .rst, .run, .mem_req(fetch_req), .mem_rsp(fetch_rsp), .instr, .instr_valid, .done
  );

  instr_executor #(.ADDR_W(ADDR_W)) instr_executor_i (
    .clk, .rst, .run, .instr, .instr_valid, .mem_req(exec_req), .mem_rsp(exec_rsp),
    .done, .halt
  );

endmodule

/* verification/cpu_model.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int AW        = cpu_pkg::ADDR_W;
localparam int PB        = cpu_pkg::PAGE_BYTES;
localparam int NSEG      = cpu_pkg::NUM_SEGS;
localparam int MEM_BYTES = 2 ** cpu_pkg::ADDR_W;

logic [7:0]  model_mem [MEM_BYTES]; // expected physical image
logic [7:0]  seg_next [NSEG];
logic [7:0]  seg_page [NSEG];
logic [7:0]  root_seg;
logic [31:0] prog [$];              // program words, logical address 4 * index
int          seed = 93;

function automatic void model_clear();
  foreach (model_mem[a]) model_mem[a] = 8'h00;
  foreach (seg_next[s]) begin
    seg_next[s] = 8'(s); // each segment ends its own chain after reset
    seg_page[s] = 8'h00;
  end
  root_seg = 8'h00;
endfunction

// walk the chain from the start segment, page 0 always lives there
function automatic bit translate(input logic [AW-1:0] laddr, output logic [AW-1:0] paddr);
  int page;
  int seg;
  int hop;
  page  = int'(laddr) / PB;
  seg   = int'(root_seg) % NSEG;
  paddr = '0;
  for (hop = 0; hop <= NSEG; hop++) begin
    if ((hop == 0 && page == 0) || int'(seg_page[seg]) == page) begin
      paddr = AW'(seg * PB + int'(laddr) % PB);
      return 1'b1;
    end
    if (int'(seg_next[seg]) == seg) return 1'b0; // end of chain
    seg = int'(seg_next[seg]);
  end
  return 1'b0;
endfunction

// runs the program over logical memory, returns 1 on a translation fault
function automatic bit model_run();
  logic [cpu_pkg::REG_W-1:0] regs [cpu_pkg::NUM_REGS];
  logic [7:0]                b [4];
  logic [AW-1:0]             pc, pa, addr;
  logic [3:0]                sel;
  int                        step, k;
  foreach (regs[r]) regs[r] = '0;
  pc = '0;
  for (step = 0; step < 64; step++) begin
    for (k = 0; k < 4; k++) begin
      if (!translate(pc + AW'(k), pa)) return 1'b1;
      b[k] = model_mem[pa];
    end
    sel  = b[1][3:0];
    addr = AW'({b[2], b[3]});
    if (b[0] == cpu_pkg::OP_HALT) return 1'b0;
    if (b[0] == cpu_pkg::OP_RAM2REG || b[0] == cpu_pkg::OP_REG2RAM) begin
      if (!translate(addr, pa)) return 1'b1;
      if (b[0] == cpu_pkg::OP_RAM2REG) regs[sel] = {8'h00, model_mem[pa]};
      else model_mem[pa] = regs[sel][7:0];
    end
    if (b[0] == cpu_pkg::OP_NUM2REG) regs[sel] = {b[2], b[3]};
    pc = (b[0] == cpu_pkg::OP_JMP) ? addr : pc + AW'(4);
  end
  return 1'b0;
endfunction

function automatic logic [15:0] data_addr();
  return 16'(PB + {$random(seed)} % (MEM_BYTES - PB)); // anywhere past page 0
endfunction

function automatic logic [31:0] random_op();
  logic [7:0]  op;
  logic [7:0]  rsel;
  logic [15:0] operand;
  case ({$random(seed)} % 3)
    0:       op = cpu_pkg::OP_NUM2REG;
    1:       op = cpu_pkg::OP_REG2RAM;
    default: op = cpu_pkg::OP_RAM2REG;
  endcase
  rsel = 8'($random(seed)); // upper bits ignored by the core
  if (op == cpu_pkg::OP_NUM2REG) operand = 16'($random(seed));
  else operand = data_addr();
  return {op, rsel, operand};
endfunction

function automatic void build_program();
  int n, jpos, w;
  logic [7:0] rsel;
  prog.delete();
  n    = 6 + ({$random(seed)} % 7);
  jpos = {$random(seed)} % (n - 3);
  for (w = 0; w < n - 3; w++) begin
    if (w == jpos) begin
      rsel = 8'($random(seed));
      prog.push_back({cpu_pkg::OP_JMP, 8'h00, 16'(4 * prog.size() + 8)}); // over one word
      prog.push_back({cpu_pkg::OP_REG2RAM, rsel, data_addr()});
    end
    prog.push_back(random_op());
  end
  prog.push_back({cpu_pkg::OP_HALT, 24'h000000});
endfunction

`endif

/* verification/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;

  `include "cpu_model.svh"

  localparam int NUM_PROGS   = 4;
  localparam int CORE_CYCLES = NUM_PROGS * 12 * 4 * (2 + cpu_pkg::NUM_SEGS) * 8;
  localparam int AXI_CYCLES  = NUM_PROGS * (MEM_BYTES + 128) * 8; // dumps, loads, polls
  localparam int CYCLE_LIMIT = CORE_CYCLES + AXI_CYCLES;

  logic               clk = 1'b0;
  logic               rst;
  cpu_pkg::axil_req_t axil_req;
  cpu_pkg::axil_rsp_t axil_rsp;
  int                 cycle_count = 0;

  cpu_top cpu_top_i (.clk, .rst, .axil_req, .axil_rsp);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic reset_dut();
    rst = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    model_clear();
  endtask

  task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    logic seen;
    logic wrdy;
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    do begin
      @(negedge clk);
      seen = axil_rsp.awready; // sampled mid-cycle
      wrdy = axil_rsp.wready;
      next_cycle();
    end while (!seen);
    check_equal("write data accepted with address", 32'(wrdy), 32'h1);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    do begin
      @(negedge clk);
      seen = axil_rsp.bvalid;
      resp = axil_rsp.bresp;
      next_cycle();
    end while (!seen);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    logic seen;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    do begin
      @(negedge clk);
      seen = axil_rsp.arready;
      next_cycle();
    end while (!seen);
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    do begin
      @(negedge clk);
      seen = axil_rsp.rvalid;
      data = axil_rsp.rdata;
      resp = axil_rsp.rresp;
      next_cycle();
    end while (!seen);
    axil_req.rready = 1'b0;
  endtask

  // order[i] is the segment that holds logical page i
  task automatic setup_chain(input int order[$]);
    int         i, nxt;
    logic [1:0] resp;
    for (i = 0; i < order.size(); i++) begin
      nxt = (i == order.size() - 1) ? order[i] : order[i + 1];
      seg_next[order[i]] = 8'(nxt);
      seg_page[order[i]] = 8'(i);
      axil_write(16'(cpu_pkg::REG_SEG_BASE + 4 * order[i]), {16'h0, 8'(i), 8'(nxt)}, resp);
    end
    root_seg = 8'(order[0]);
    axil_write(cpu_pkg::REG_START_SEG, {24'h0, root_seg}, resp);
  endtask

  task automatic load_byte(input logic [AW-1:0] laddr, input logic [7:0] value);
    logic [AW-1:0] pa;
    logic [1:0]    resp;
    if (!translate(laddr, pa)) begin
      $display("test setup error, logical address 0x%0h has no segment", laddr);
      $display("*** FAILED ***");
      $fatal(1, "unmapped load address");
    end else begin
      model_mem[pa] = value;
      axil_write(16'(cpu_pkg::MEM_BASE + 4 * pa), {24'h0, value}, resp);
      check_equal("host memory write response", 32'(resp), 32'(cpu_pkg::RESP_OKAY));
    end
  endtask

  task automatic load_program();
    int w, k;
    for (w = 0; w < prog.size(); w++) begin
      for (k = 0; k < 4; k++) load_byte(AW'(4 * w + k), prog[w][31 - 8 * k -: 8]);
    end
  endtask

  task automatic preload_data();
    repeat (16) load_byte(AW'(data_addr()), 8'($random(seed)));
  endtask

  task automatic compare_memory();
    logic [31:0] data;
    logic [1:0]  resp;
    int          a;
    for (a = 0; a < MEM_BYTES; a++) begin
      axil_read(16'(cpu_pkg::MEM_BASE + 4 * a), data, resp);
      check_equal("memory read response", 32'(resp), 32'(cpu_pkg::RESP_OKAY));
      check_equal($sformatf("physical byte 0x%0h", a), data, {24'h0, model_mem[a]});
    end
  endtask

  task automatic run_and_check();
    logic [31:0] ctrl;
    logic [1:0]  resp;
    bit          fault_exp;
    fault_exp = model_run();
    axil_write(cpu_pkg::REG_CTRL, 32'h1, resp);
    do axil_read(cpu_pkg::REG_CTRL, ctrl, resp); while (ctrl[0]); // poll until run drops
    check_equal("control after run", ctrl, {30'h0, fault_exp, 1'b0});
    compare_memory();
  endtask

  initial begin
    logic [31:0]   data;
    logic [1:0]    resp;
    logic [AW-1:0] addr, pa;
    logic [7:0]    value;
    logic [15:0]   src, dst, skip;
    int            order[$];
    int            i, j, tmp;
    axil_req = '0;
    reset_dut();

    axil_read(cpu_pkg::REG_CTRL, data, resp);
    check_equal("control after reset", data, 32'h0);
    addr  = AW'($random(seed));
    value = 8'($random(seed));
    axil_write(16'(cpu_pkg::MEM_BASE + 4 * addr), {24'h0, value}, resp);
    check_equal("memory write response", 32'(resp), 32'(cpu_pkg::RESP_OKAY));
    axil_read(16'(cpu_pkg::MEM_BASE + 4 * addr), data, resp);
    check_equal("memory read response", 32'(resp), 32'(cpu_pkg::RESP_OKAY));
    check_equal("memory read back", data, {24'h0, value});

    reset_dut(); // identity chain, random program
    for (i = 0; i < NSEG; i++) order.push_back(i);
    setup_chain(order);
    preload_data();
    build_program();
    load_program();
    run_and_check();

    reset_dut(); // copy a byte, jump over a store
    setup_chain(order);
    src  = data_addr();
    dst  = data_addr();
    skip = data_addr();
    prog.delete();
    prog.push_back({cpu_pkg::OP_RAM2REG, 8'h03, src});
    prog.push_back({cpu_pkg::OP_REG2RAM, 8'h03, dst});
    prog.push_back({cpu_pkg::OP_JMP, 8'h00, 16'd16});
    prog.push_back({cpu_pkg::OP_REG2RAM, 8'h03, skip});
    prog.push_back({cpu_pkg::OP_HALT, 24'h000000});
    load_program();
    load_byte(AW'(src), 8'h80 | 8'($random(seed)));
    run_and_check();

    reset_dut(); // shuffled chain
    for (i = NSEG - 1; i > 0; i--) begin
      j        = {$random(seed)} % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    setup_chain(order);
    preload_data();
    build_program();
    load_program();
    run_and_check();

    reset_dut(); // half the pages mapped, load from an unmapped one
    order.delete();
    for (i = 0; i < NSEG / 2; i++) order.push_back(i);
    setup_chain(order);
    prog.delete();
    prog.push_back({cpu_pkg::OP_NUM2REG, 8'h05, 16'h00a5});
    prog.push_back({cpu_pkg::OP_RAM2REG, 8'h05, 16'((NSEG - 4) * PB)});
    prog.push_back({cpu_pkg::OP_HALT, 24'h000000});
    load_program();
    run_and_check();

    prog.delete();
    prog.push_back({cpu_pkg::OP_JMP, 8'h00, 16'h0000}); // spins until stopped
    load_program();
    addr  = AW'(PB + 5);
    value = 8'h5a;
    load_byte(addr, value);
    void'(translate(addr, pa));
    axil_write(cpu_pkg::REG_CTRL, 32'h1, resp);
    axil_write(16'(cpu_pkg::MEM_BASE + 4 * pa), {24'h0, ~value}, resp);
    check_equal("write response while running", 32'(resp), 32'(cpu_pkg::RESP_SLVERR));
    axil_read(16'(cpu_pkg::MEM_BASE + 4 * pa), data, resp);
    check_equal("read response while running", 32'(resp), 32'(cpu_pkg::RESP_SLVERR));
    check_equal("read data while running", data, 32'h0);
    axil_write(cpu_pkg::REG_CTRL, 32'h0, resp);
    axil_read(16'(cpu_pkg::MEM_BASE + 4 * pa), data, resp);
    check_equal("memory after refused write", data, {24'h0, model_mem[pa]});

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* compile.f */
+incdir+verification
source/cpu_pkg.sv
source/byte_memory.sv
source/page_translator.sv
source/host_port.sv
source/instr_fetcher.sv
source/instr_executor.sv
source/cpu_top.sv
verification/cpu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= cpu_tb
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	./$(OBJ_DIR)/$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
